// ==== src/game_defs.svh ====
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Region starts in SDRAM half-words
`define SND_OFFSET 22'h1_0000
`define GFX_OFFSET 22'h1_4000

// First download byte not kept
`define ROM_END 25'h0_A8000

// Client address widths
`define MAIN_AW 17
`define SND_AW 15
`define GFX_AW 18

`endif

// ==== src/game_pkg.sv ====
`default_nettype none

package game_pkg;

    typedef logic [21:0] sdram_addr_t;  // Half-word address
    typedef logic [31:0] sdram_data_t;  // One burst of two half-words
    typedef logic [15:0] rom_half_t;
    typedef logic [ 7:0] byte_t;

    // Read request, slot to arbiter and arbiter to SDRAM
    typedef struct packed {
        logic        req;
        sdram_addr_t addr;
    } sdram_rd_t;

    // Byte write toward SDRAM
    typedef struct packed {
        logic        we;
        sdram_addr_t addr;
        byte_t       data;
        logic [1:0]  mask;  // Active low lane mask
    } prog_wr_t;

endpackage

`default_nettype wire

// ==== src/prom_loader.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_defs.svh"

module prom_loader (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               downloading,
    input  logic               ioctl_wr,
    input  logic [24:0]        ioctl_addr,
    input  game_pkg::byte_t    ioctl_data,
    input  logic               sdram_ack,
    output game_pkg::prog_wr_t prog
);
    import game_pkg::*;

    logic        accept;
    logic        we;
    sdram_addr_t addr_q;
    byte_t       data_q;
    logic [1:0]  mask_q;

    // Bytes past the ROM area are dropped
    assign accept = downloading && ioctl_wr && (ioctl_addr < `ROM_END);

    // Write request stays up until the SDRAM takes it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we <= 1'b0;
        end else if (accept) begin
            we <= 1'b1;
        end else if (sdram_ack) begin
            we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= ioctl_addr[22:1];  // Byte to half-word
            data_q <= ioctl_data;
            // Odd bytes go to the upper lane
            if (ioctl_addr[0]) begin
                mask_q <= 2'b01;
            end else begin
                mask_q <= 2'b10;
            end
        end
    end

    assign prog = '{we: we, addr: addr_q, data: data_q, mask: mask_q};

endmodule

`default_nettype wire

// ==== src/rom_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter int                    AW     = 17,
    parameter int                    DW     = 8,
    parameter game_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  downloading,
    input  logic                  cs,
    input  logic [AW-1:0]         addr,
    output logic [DW-1:0]         data,
    output logic                  ok,
    output game_pkg::sdram_rd_t   rd,
    input  logic                  rdy,
    input  game_pkg::sdram_data_t rd_data
);
    import game_pkg::*;

    localparam int SHIFT = (DW == 8) ? 1 : 0;  // Byte clients drop bit 0

    sdram_addr_t word_addr;
    sdram_addr_t tag_q;
    sdram_addr_t req_addr;
    rom_half_t   word_q;
    logic        valid;
    logic        busy;
    logic        dl_q;
    logic        hit;
    logic        fill;
    logic        fill_hit;
    logic        start;
    logic        clear;

    assign word_addr = OFFSET + sdram_addr_t'(addr >> SHIFT);
    assign hit       = valid && (tag_q == word_addr);
    assign fill      = busy && rdy;
    assign fill_hit  = fill && (req_addr == word_addr);  // Data arriving for this address
    assign start     = cs && !hit && !busy;
    assign clear     = downloading && !dl_q;              // Download restarted

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            busy  <= 1'b0;
            ok    <= 1'b0;
            dl_q  <= 1'b0;
        end else begin
            dl_q <= downloading;
            ok   <= cs && !clear && (hit || fill_hit);
            if (clear) begin
                valid <= 1'b0;
            end else if (fill) begin
                valid <= 1'b1;
            end
            // One outstanding read at a time
            if (fill) begin
                busy <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= word_addr;  // Held for the whole request
        end
        if (fill) begin
            tag_q  <= req_addr;
            word_q <= rd_data[15:0];  // Lower half-word only
        end
    end

    assign rd = '{req: busy, addr: req_addr};

    generate
        if (DW == 8) begin : g_byte
            assign data = addr[0] ? word_q[15:8] : word_q[7:0];
        end else begin : g_half
            assign data = word_q;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== src/rom_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    input  logic                lvbl,
    input  game_pkg::sdram_rd_t gfx_rd,
    input  game_pkg::sdram_rd_t snd_rd,
    input  game_pkg::sdram_rd_t main_rd,
    output logic                gfx_rdy,
    output logic                snd_rdy,
    output logic                main_rdy,
    output game_pkg::sdram_rd_t sdram,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    output logic                refresh_en
);
    import game_pkg::*;

    logic        busy;
    logic        req_q;       // Address phase, cleared by ack
    sdram_addr_t addr_q;
    logic [2:0]  owner;       // One-hot gfx, snd, main
    logic [2:0]  pick;
    sdram_addr_t pick_addr;
    logic        pending;
    logic        start;
    logic        done;

    // Fixed priority, gfx first
    always_comb begin
        pick      = 3'b000;
        pick_addr = main_rd.addr;
        if (gfx_rd.req) begin
            pick      = 3'b100;
            pick_addr = gfx_rd.addr;
        end else if (snd_rd.req) begin
            pick      = 3'b010;
            pick_addr = snd_rd.addr;
        end else if (main_rd.req) begin
            pick = 3'b001;
        end
    end

    assign pending = gfx_rd.req || snd_rd.req || main_rd.req;
    assign start   = !busy && pending && !downloading;  // No reads while loading
    assign done    = busy && !req_q && data_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            req_q      <= 1'b0;
            owner      <= 3'b000;
            refresh_en <= 1'b0;
        end else begin
            // Refresh only in blanking with the bus free
            refresh_en <= !busy && !pending && !lvbl;
            if (start) begin
                busy  <= 1'b1;
                req_q <= 1'b1;
                owner <= pick;
            end else begin
                if (req_q && sdram_ack) begin
                    req_q <= 1'b0;
                end
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= pick_addr;
        end
    end

    assign sdram = '{req: req_q, addr: addr_q};

    // Ready goes straight back while data_read is valid
    assign gfx_rdy  = done && owner[2];
    assign snd_rdy  = done && owner[1];
    assign main_rdy = done && owner[0];

endmodule

`default_nettype wire

// ==== src/game_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_defs.svh"

module game_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  downloading,
    input  logic                  lvbl,
    // ROM download
    input  logic [24:0]           ioctl_addr,
    input  game_pkg::byte_t       ioctl_data,
    input  logic                  ioctl_wr,
    output game_pkg::sdram_addr_t prog_addr,
    output game_pkg::byte_t       prog_data,
    output logic [1:0]            prog_mask,  // active low
    output logic                  prog_we,
    // Main CPU ROM
    input  logic                  main_cs,
    input  logic [`MAIN_AW-1:0]   main_addr,
    output game_pkg::byte_t       main_data,
    output logic                  main_ok,
    // Sound CPU ROM
    input  logic                  snd_cs,
    input  logic [`SND_AW-1:0]    snd_addr,
    output game_pkg::byte_t       snd_data,
    output logic                  snd_ok,
    // Graphics ROM
    input  logic [`GFX_AW-1:0]    gfx_addr,
    output game_pkg::rom_half_t   gfx_data,
    output logic                  gfx_ok,
    // SDRAM
    output logic                  sdram_req,
    output game_pkg::sdram_addr_t sdram_addr,
    input  game_pkg::sdram_data_t data_read,
    input  logic                  sdram_ack,
    input  logic                  data_rdy,
    output logic                  refresh_en
);
    import game_pkg::*;

    prog_wr_t  prog;
    sdram_rd_t main_rd;
    sdram_rd_t snd_rd;
    sdram_rd_t gfx_rd;
    sdram_rd_t sdram;
    logic      main_rdy;
    logic      snd_rdy;
    logic      gfx_rdy;

    // Ack is shared, reads are held off during download
    prom_loader u_loader (
        .clk         ( clk          ),
        .arst_n      ( arst_n       ),
        .downloading ( downloading  ),
        .ioctl_wr    ( ioctl_wr     ),
        .ioctl_addr  ( ioctl_addr   ),
        .ioctl_data  ( ioctl_data   ),
        .sdram_ack   ( sdram_ack    ),
        .prog        ( prog         )
    );

    assign prog_we   = prog.we;
    assign prog_addr = prog.addr;
    assign prog_data = prog.data;
    assign prog_mask = prog.mask;

    rom_slot #(.AW(`MAIN_AW), .DW(8), .OFFSET(22'd0)) u_main (
        .clk         ( clk          ),
        .arst_n      ( arst_n       ),
        .downloading ( downloading  ),
        .cs          ( main_cs      ),
        .addr        ( main_addr    ),
        .data        ( main_data    ),
        .ok          ( main_ok      ),
        .rd          ( main_rd      ),
        .rdy         ( main_rdy     ),
        .rd_data     ( data_read    )
    );

    rom_slot #(.AW(`SND_AW), .DW(8), .OFFSET(`SND_OFFSET)) u_snd (
        .clk         ( clk          ),
        .arst_n      ( arst_n       ),
        .downloading ( downloading  ),
        .cs          ( snd_cs       ),
        .addr        ( snd_addr     ),
        .data        ( snd_data     ),
        .ok          ( snd_ok       ),
        .rd          ( snd_rd       ),
        .rdy         ( snd_rdy      ),
        .rd_data     ( data_read    )
    );

    rom_slot #(.AW(`GFX_AW), .DW(16), .OFFSET(`GFX_OFFSET)) u_gfx (
        .clk         ( clk          ),
        .arst_n      ( arst_n       ),
        .downloading ( downloading  ),
        .cs          ( lvbl         ),  // Fetch outside vertical blank
        .addr        ( gfx_addr     ),
        .data        ( gfx_data     ),
        .ok          ( gfx_ok       ),
        .rd          ( gfx_rd       ),
        .rdy         ( gfx_rdy      ),
        .rd_data     ( data_read    )
    );

    rom_arbiter u_arb (
        .clk         ( clk          ),
        .arst_n      ( arst_n       ),
        .downloading ( downloading  ),
        .lvbl        ( lvbl         ),
        .gfx_rd      ( gfx_rd       ),
        .snd_rd      ( snd_rd       ),
        .main_rd     ( main_rd      ),
        .gfx_rdy     ( gfx_rdy      ),
        .snd_rdy     ( snd_rdy      ),
        .main_rdy    ( main_rdy     ),
        .sdram       ( sdram        ),
        .sdram_ack   ( sdram_ack    ),
        .data_rdy    ( data_rdy     ),
        .refresh_en  ( refresh_en   )
    );

    assign sdram_req  = sdram.req;
    assign sdram_addr = sdram.addr;

endmodule

`default_nettype wire

// ==== test/game_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_props (
    input logic                clk,
    input logic                arst_n,
    input logic                downloading,
    input game_pkg::sdram_rd_t sdram,
    input logic                sdram_ack,
    input logic                refresh_en
);
    import game_pkg::*;

    // Address phase held until the SDRAM takes it
    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        sdram.req && !sdram_ack |=> sdram.req && $stable(sdram.addr))
        else $error("SDRAM request changed before ack");

    a_no_dl_read: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(sdram.req) |-> !$past(downloading))
        else $error("SDRAM read started during download");

    a_refresh_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !(refresh_en && sdram.req))
        else $error("Refresh enabled with a read pending");

endmodule

bind rom_arbiter game_props u_props (
    .clk         ( clk         ),
    .arst_n      ( arst_n      ),
    .downloading ( downloading ),
    .sdram       ( sdram       ),
    .sdram_ack   ( sdram_ack   ),
    .refresh_en  ( refresh_en  )
);

`default_nettype wire

// ==== test/game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_defs.svh"

module game_tb;
    import game_pkg::*;

    typedef struct {
        int kind;  // 0 main, 1 sound, 2 gfx
        int addr;
        bit hit;
    } row_t;

    localparam int NROWS = 11;

    logic                clk;
    logic                arst_n;
    logic                downloading;
    logic                lvbl;
    logic [24:0]         ioctl_addr;
    byte_t               ioctl_data;
    logic                ioctl_wr;
    sdram_addr_t         prog_addr;
    byte_t               prog_data;
    logic [1:0]          prog_mask;
    logic                prog_we;
    logic                main_cs;
    logic [`MAIN_AW-1:0] main_addr;
    byte_t               main_data;
    logic                main_ok;
    logic                snd_cs;
    logic [`SND_AW-1:0]  snd_addr;
    byte_t               snd_data;
    logic                snd_ok;
    logic [`GFX_AW-1:0]  gfx_addr;
    rom_half_t           gfx_data;
    logic                gfx_ok;
    logic                sdram_req;
    sdram_addr_t         sdram_addr;
    sdram_data_t         data_read;
    logic                ack_wr;
    logic                ack_rd;
    logic                sdram_ack;
    logic                data_rdy;
    logic                refresh_en;

    byte_t     byte_map[int];  // Bytes as downloaded
    rom_half_t mem[int];       // SDRAM contents by half-word
    int        image[$];
    int        errors = 0;
    int        failed_tests = 0;
    int        cycles = 0;
    int        limit = 0;
    row_t      rows[NROWS] = '{
        '{0, 'h04, 0}, '{0, 'h05, 1}, '{0, 'h04, 1}, '{0, 'h11, 0},
        '{1, 'h02, 0}, '{1, 'h03, 1}, '{1, 'h1c, 0},
        '{2, 'h03, 0}, '{2, 'h03, 1}, '{2, 'h10, 0}, '{0, 'h10, 1}
    };

    assign sdram_ack = ack_wr || ack_rd;

    game_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: the DUT stopped responding after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic byte_t byte_at(input int a);
        return byte_map.exists(a) ? byte_map[a] : 8'h00;
    endfunction

    function automatic rom_half_t half_at(input int w);
        return mem.exists(w) ? mem[w] : 16'h0000;
    endfunction

    // Expected read from the byte map and the region offsets
    function automatic logic [15:0] expect_data(input int kind, input int a);
        int w;
        if (kind == 0) return {8'h00, byte_at(a)};
        if (kind == 1) return {8'h00, byte_at(int'(`SND_OFFSET) * 2 + a)};
        w = int'(`GFX_OFFSET) + a;
        return {byte_at(2 * w + 1), byte_at(2 * w)};
    endfunction

    function automatic logic port_ok(input int kind);
        return (kind == 0) ? main_ok : (kind == 1) ? snd_ok : gfx_ok;
    endfunction

    function automatic logic [15:0] port_data(input int kind);
        if (kind == 0) return {8'h00, main_data};
        if (kind == 1) return {8'h00, snd_data};
        return gfx_data;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Write model merging each byte into its lane
    always @(posedge clk) begin
        rom_half_t h;
        if (prog_we) begin
            h = half_at(int'(prog_addr));
            if (!prog_mask[0]) h[7:0] = prog_data;
            if (!prog_mask[1]) h[15:8] = prog_data;
            mem[int'(prog_addr)] = h;
            repeat ($urandom_range(4, 1) - 1) @(posedge clk);
            ack_wr <= 1'b1;
            @(posedge clk);
            ack_wr <= 1'b0;
        end
    end

    // Read model with random ack and data latency
    always @(posedge clk) begin
        int w;
        if (sdram_req) begin
            w = int'(sdram_addr);
            repeat ($urandom_range(4, 1) - 1) @(posedge clk);
            ack_rd <= 1'b1;
            @(posedge clk);
            ack_rd <= 1'b0;
            repeat ($urandom_range(4, 1) - 1) @(posedge clk);
            data_read <= {half_at(w + 1), half_at(w)};
            data_rdy  <= 1'b1;
            @(posedge clk);
            data_rdy  <= 1'b0;
        end
    end

    task automatic load_byte(input int a, input byte_t d);
        @(posedge clk);
        ioctl_addr <= 25'(a);
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
        if (a < int'(`ROM_END)) begin
            wait (prog_we);
            #1;
            check_value("prog_addr", 32'(a >> 1), 32'(prog_addr));
            check_value("prog_data", 32'(d), 32'(prog_data));
            check_value("prog_mask", (a % 2 == 1) ? 32'd1 : 32'd2, 32'(prog_mask));
            byte_map[a] = d;
            wait (!prog_we);
        end else begin
            repeat (6) begin
                @(posedge clk);
                #1;
                if (prog_we) begin
                    $display("A byte beyond the ROM end at %h produced a write", a);
                    errors++;
                end
            end
        end
    endtask

    task automatic drive_port(input int kind, input int a);
        @(posedge clk);
        case (kind)
            0: begin
                main_cs   <= 1'b1;
                main_addr <= `MAIN_AW'(a);
            end
            1: begin
                snd_cs   <= 1'b1;
                snd_addr <= `SND_AW'(a);
            end
            default: begin
                lvbl     <= 1'b1;
                gfx_addr <= `GFX_AW'(a);
            end
        endcase
    endtask

    task automatic release_ports();
        @(posedge clk);
        main_cs <= 1'b0;
        snd_cs  <= 1'b0;
        lvbl    <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic read_port(input int kind, input int a, output int lat);
        drive_port(kind, a);
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!port_ok(kind));
    endtask

    task automatic finish_test(input int num, input string what, input int err_before);
        if (errors == err_before) begin
            $display("Test %0d (%s): passed", num, what);
        end else begin
            $display("Test %0d (%s): failed", num, what);
            failed_tests++;
        end
    endtask

    initial begin
        int lat;
        int e0;
        int t_main;
        int t_snd;
        int t_gfx;
        {downloading, lvbl, ioctl_addr, ioctl_data, ioctl_wr} = '0;
        {main_cs, main_addr, snd_cs, snd_addr, gfx_addr} = '0;
        {data_read, ack_wr, ack_rd, data_rdy} = '0;
        arst_n = 1'b0;
        void'($urandom(32'ha1d5_8625));
        for (int i = 0; i < 32; i++) image.push_back(i);
        for (int i = 0; i < 32; i++) image.push_back(int'(`SND_OFFSET) * 2 + i);
        for (int i = 0; i < 64; i++) image.push_back(int'(`GFX_OFFSET) * 2 + i);
        image.push_back(int'(`ROM_END));
        image.push_back(int'(`ROM_END) + 1);
        image.push_back('h0B_0000);
        limit = 200 * (NROWS + 4) + 20 * image.size();
        repeat (9) @(posedge clk);
        #1;
        e0 = errors;
        check_value("main_ok", 32'd0, 32'(main_ok));
        check_value("snd_ok", 32'd0, 32'(snd_ok));
        check_value("gfx_ok", 32'd0, 32'(gfx_ok));
        check_value("sdram_req", 32'd0, 32'(sdram_req));
        check_value("prog_we", 32'd0, 32'(prog_we));
        check_value("refresh_en", 32'd0, 32'(refresh_en));
        finish_test(0, "reset", e0);
        @(posedge clk);
        arst_n <= 1'b1;

        e0 = errors;
        @(posedge clk);
        downloading <= 1'b1;
        foreach (image[i]) load_byte(image[i], byte_t'($urandom));
        @(posedge clk);
        downloading <= 1'b0;
        repeat (4) @(posedge clk);
        finish_test(1, "download", e0);

        foreach (rows[i]) begin
            e0 = errors;
            read_port(rows[i].kind, rows[i].addr, lat);
            if (rows[i].hit && lat != 1) begin
                $display("Row %0d should hit but took %0d cycles", i, lat);
                errors++;
            end
            if (!rows[i].hit && lat == 1) begin
                $display("Row %0d should miss but answered at once", i);
                errors++;
            end
            check_value("rom_data", 32'(expect_data(rows[i].kind, rows[i].addr)),
                        32'(port_data(rows[i].kind)));
            release_ports();
            finish_test(2 + i, rows[i].hit ? "hit" : "miss", e0);
        end

        // Gfx stays idle in blanking and refresh runs
        e0 = errors;
        @(posedge clk);
        gfx_addr <= `GFX_AW'(8);
        repeat (20) @(posedge clk);
        #1;
        check_value("gfx_ok", 32'd0, 32'(gfx_ok));
        check_value("refresh_en", 32'd1, 32'(refresh_en));
        finish_test(2 + NROWS, "blanking", e0);

        // New download clears every cached entry
        e0 = errors;
        @(posedge clk);
        downloading <= 1'b1;
        snd_cs      <= 1'b1;  // Sound miss waits for the download to end
        snd_addr    <= `SND_AW'('h0a);
        load_byte('h10, byte_at('h10) ^ 8'h5a);
        @(posedge clk);
        downloading <= 1'b0;
        repeat (4) @(posedge clk);
        read_port(0, 'h10, lat);
        if (lat == 1) begin
            $display("Cached byte survived the new download");
            errors++;
        end
        check_value("main_data", 32'(expect_data(0, 'h10)), 32'(main_data));
        check_value("snd_ok", 32'd1, 32'(snd_ok));
        check_value("snd_data", 32'(expect_data(1, 'h0a)), 32'(snd_data));
        release_ports();
        finish_test(3 + NROWS, "re-download", e0);

        // All three miss on the same edge
        e0 = errors;
        t_main = 0;
        t_snd  = 0;
        t_gfx  = 0;
        @(posedge clk);
        main_cs  <= 1'b1;
        main_addr <= `MAIN_AW'('h1a);
        snd_cs   <= 1'b1;
        snd_addr <= `SND_AW'('h08);
        lvbl     <= 1'b1;
        gfx_addr <= `GFX_AW'('h1e);
        for (int c = 1; t_main == 0 || t_snd == 0 || t_gfx == 0; c++) begin
            @(posedge clk);
            #1;
            if (main_ok && t_main == 0) t_main = c;
            if (snd_ok && t_snd == 0) t_snd = c;
            if (gfx_ok && t_gfx == 0) t_gfx = c;
        end
        if (t_gfx >= t_snd || t_gfx >= t_main) begin
            $display("Gfx was not served first under contention");
            errors++;
        end
        check_value("main_data", 32'(expect_data(0, 'h1a)), 32'(main_data));
        check_value("snd_data", 32'(expect_data(1, 'h08)), 32'(snd_data));
        check_value("gfx_data", 32'(expect_data(2, 'h1e)), 32'(gfx_data));
        release_ports();
        finish_test(4 + NROWS, "contention", e0);

        $display("Tests run %0d, failed %0d, errors %0d", 5 + NROWS, failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/game_pkg.sv
src/prom_loader.sv
src/rom_slot.sv
src/rom_arbiter.sv
src/game_top.sv
test/game_props.sv
test/game_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module game_tb -o game_sim &&
./obj_dir/game_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed"; exit 1; }
